// ==== sim.f ====
src/obi_mux_pkg.sv
src/obi_rr_arbiter.sv
src/obi_id_fifo.sv
src/obi_rsp_router.sv
src/obi_mux.sv
tb/obi_mux_tb.sv

// ==== tb/obi_mux_stim.txt ====
# name port gap addr we wdata gnt_dly rsp_dly exp_rdata exp_err
# gap is idle cycles before the request, -1 picks a random gap of 0 to 3
single_wr 2 0 00000020 1 DEADBEEF 1 2 00000000 0
rd_after_wr 0 0 00000020 0 00000000 0 1 DEADBEEF 0
err_rd 3 0 80000004 0 00000000 0 1 25A50004 1
single_rd 1 0 00000010 0 00000000 0 1 A5A50010 0
round_robin 0 0 00000100 0 00000000 0 1 A5A50100 0
round_robin 1 0 00000104 0 00000000 0 1 A5A50104 0
round_robin 2 0 00000108 0 00000000 0 1 A5A50108 0
round_robin 3 0 0000010C 0 00000000 0 1 A5A5010C 0
round_robin 0 0 00000110 0 00000000 0 1 A5A50110 0
round_robin 1 0 00000114 1 0BADF00D 0 1 00000000 0
round_robin 2 0 00000118 0 00000000 0 1 A5A50118 0
round_robin 3 0 0000011C 1 0000F00D 0 1 00000000 0
lock_in 1 0 00000200 0 00000000 5 1 A5A50200 0
lock_in 2 2 00000204 1 12345678 0 2 00000000 0
lock_in 3 2 00000208 0 00000000 1 1 A5A50208 0
outstanding 0 0 00000300 0 00000000 0 8 A5A50300 0
outstanding 1 0 00000308 0 00000000 0 8 A5A50308 0
outstanding 2 0 0000030C 0 00000000 0 8 A5A5030C 0
outstanding 3 0 80000330 0 00000000 0 8 25A50330 1
outstanding 0 0 00000310 0 00000000 0 8 A5A50310 0
outstanding 1 0 00000328 1 0BEE0328 0 8 00000000 0
mixed 0 -1 00000440 1 CAFE0001 2 3 00000000 0
mixed 1 -1 00000020 0 00000000 0 2 DEADBEEF 0
mixed 2 -1 00000448 0 00000000 1 1 A5A50448 0
mixed 3 -1 8000044C 1 FFFF0000 0 4 00000000 1
mixed 0 -1 00000450 0 00000000 0 1 A5A50450 0
mixed 1 -1 00000454 0 00000000 3 2 A5A50454 0
mixed 2 -1 00000458 1 0000BEEF 0 5 00000000 0
mixed 3 -1 0000045C 0 00000000 2 1 A5A5045C 0
same_port 2 0 00000500 0 00000000 0 1 A5A50500 0
same_port 2 0 00000504 1 00C0FFEE 0 1 00000000 0
same_port 2 0 00000504 0 00000000 0 1 00C0FFEE 0
same_port 2 0 00000508 0 00000000 0 1 A5A50508 0

// ==== tb/obi_mux_tb.sv ====
/*
 * Testbench for the OBI request multiplexer.
 * Replays a transaction list against a cycle model of the arbitration,
 * the outstanding limit and an in-order manager memory.
 */
`timescale 1ns/100ps
`default_nettype none

module obi_mux_tb;

  import obi_mux_pkg::*;

  localparam int unsigned NumSbrPorts = 4;
  localparam int unsigned NumMaxTrans = 4;
  localparam int unsigned IdxWidth    = $clog2(NumSbrPorts);
  localparam int unsigned MaxTx       = 64;
  localparam int          BatchCycles = 300;

  logic                       clk_i;
  logic                       reset_i;
  obi_req_t [NumSbrPorts-1:0] sbr_req;
  obi_rsp_t [NumSbrPorts-1:0] sbr_rsp;
  obi_req_t                   mgr_req;
  obi_rsp_t                   mgr_rsp;

  string       tx_name  [MaxTx];
  int          tx_port  [MaxTx];
  int          tx_gap   [MaxTx];
  logic [31:0] tx_addr  [MaxTx];
  logic        tx_we    [MaxTx];
  logic [31:0] tx_wdata [MaxTx];
  int          tx_gdly  [MaxTx];
  int          tx_rdly  [MaxTx];
  logic [31:0] tx_rdata [MaxTx];
  logic        tx_err   [MaxTx];
  int          num_tx;

  // Manager memory with one word per addr[7:2].
  logic [31:0] mem     [64];
  logic        mem_vld [64];

  int          rr_ptr;
  logic        lock_vld;
  int          lock_port;
  string       test_name;

  obi_mux #(
    .NumSbrPorts ( NumSbrPorts ),
    .NumMaxTrans ( NumMaxTrans )
  ) i_obi_mux (
    .clk_i     ( clk_i   ),
    .reset_i   ( reset_i ),
    .sbr_req_i ( sbr_req ),
    .sbr_rsp_o ( sbr_rsp ),
    .mgr_req_o ( mgr_req ),
    .mgr_rsp_i ( mgr_rsp )
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %b actual %b",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic compare_idx(input string what, input logic [IdxWidth-1:0] exp,
                             input logic [IdxWidth-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %0d actual %0d",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic compare_a(input string what, input obi_a_chan_t exp, input obi_a_chan_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic compare_r(input string what, input obi_r_chan_t exp, input obi_r_chan_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
    end
  endtask

  // The aid carries the transaction number so each response can be told apart.
  function automatic obi_a_chan_t make_a(input int k);
    obi_a_chan_t a;
    a.addr  = tx_addr[k];
    a.we    = tx_we[k];
    a.be    = 4'hF;
    a.wdata = tx_wdata[k];
    a.aid   = IdWidth'(k);
    return a;
  endfunction

  function automatic obi_r_chan_t file_rsp(input int k);
    obi_r_chan_t r;
    r.rdata = tx_rdata[k];
    r.rid   = IdWidth'(k);
    r.err   = tx_err[k];
    return r;
  endfunction

  // Reads return stored data when the word was written, else addr ^ A5A5_0000.
  function automatic obi_r_chan_t memory_rsp(input int k);
    obi_r_chan_t r;
    logic [5:0]  widx;
    widx    = tx_addr[k][7:2];
    r.rid   = IdWidth'(k);
    r.err   = tx_addr[k][31];
    if (tx_we[k]) begin
      r.rdata = '0;
    end else if (!r.err && mem_vld[widx]) begin
      r.rdata = mem[widx];
    end else begin
      r.rdata = tx_addr[k] ^ 32'hA5A5_0000;
    end
    return r;
  endfunction

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    string       name;
    int          port, gap, we, gdly, rdly, err;
    logic [31:0] addr, wdata, rdata;
    fd = $fopen("tb/obi_mux_stim.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the stimulus file tb/obi_mux_stim.txt.");
    end
    num_tx = 0;
    while (!$feof(fd) && num_tx < MaxTx) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %d %d %h %d %h %d %d %h %d", name, port, gap, addr, we, wdata,
                  gdly, rdly, rdata, err);
      if (n != 10) begin
        stop_with_failure($sformatf("Stimulus line could not be parsed: %s", line));
      end
      tx_name[num_tx]  = name;
      tx_port[num_tx]  = port;
      tx_gap[num_tx]   = gap;
      tx_addr[num_tx]  = addr;
      tx_we[num_tx]    = we[0];
      tx_wdata[num_tx] = wdata;
      tx_gdly[num_tx]  = gdly;
      tx_rdly[num_tx]  = rdly;
      tx_rdata[num_tx] = rdata;
      tx_err[num_tx]   = err[0];
      num_tx++;
    end
    $fclose(fd);
  endtask

  task automatic check_idle();
    #5;
    compare_bit("manager req", 1'b0, mgr_req.req);
    for (int p = 0; p < NumSbrPorts; p++) begin
      compare_bit($sformatf("gnt of port %0d", p), 1'b0, sbr_rsp[p].gnt);
      compare_bit($sformatf("rvalid of port %0d", p), 1'b0, sbr_rsp[p].rvalid);
    end
  endtask

  // One loop pass is one clock cycle. Inputs change on the falling edge and
  // outputs are checked halfway to the next rising edge.
  task automatic run_batch(input int first, input int last);
    int                     cur  [NumSbrPorts];
    int                     scan [NumSbrPorts];
    int                     gap  [NumSbrPorts];
    int                     out_q [$];
    int                     out_ready [$];
    int                     wait_cnt, cyc, done, found, chosen, k, head, rsp_port;
    logic                   arb_req, exp_req, xfer, rsp;
    logic [NumSbrPorts-1:0] reqs;
    logic [IdxWidth-1:0]    act_idx;
    for (int p = 0; p < NumSbrPorts; p++) begin
      cur[p]  = -1;
      scan[p] = first;
      gap[p]  = 0;
    end
    wait_cnt = 0;
    cyc      = 0;
    done     = 0;
    while (done < last - first + 1) begin
      if (cyc >= BatchCycles) begin
        stop_with_failure($sformatf("Timeout in test %s: not all responses arrived.", test_name));
      end
      @(negedge clk_i);
      for (int p = 0; p < NumSbrPorts; p++) begin
        if (cur[p] < 0) begin
          for (int i = scan[p]; i <= last && cur[p] < 0; i++) begin
            if (tx_port[i] == p) begin
              cur[p]  = i;
              scan[p] = i + 1;
            end
          end
          if (cur[p] >= 0) begin
            gap[p] = (tx_gap[cur[p]] < 0) ? int'($urandom_range(3, 0)) : tx_gap[cur[p]];
          end
        end else if (gap[p] > 0) begin
          gap[p]--;
        end
        reqs[p]       = (cur[p] >= 0) && (gap[p] == 0);
        sbr_req[p].req = reqs[p];
        sbr_req[p].a   = (cur[p] >= 0) ? make_a(cur[p]) : '0;
      end

      // Round robin from the pointer. A port that waits for its grant holds the choice.
      found = -1;
      for (int i = 0; i < NumSbrPorts; i++) begin
        k = (rr_ptr + i) % int'(NumSbrPorts);
        if (found < 0 && reqs[k]) begin
          found = k;
        end
      end
      chosen  = lock_vld ? lock_port : found;
      arb_req = lock_vld ? reqs[lock_port] : (found >= 0);
      exp_req = arb_req && (out_q.size() < NumMaxTrans);
      xfer    = 1'b0;
      if (exp_req) begin
        xfer = (wait_cnt >= tx_gdly[cur[chosen]]);
      end
      rsp      = (out_q.size() > 0) && (out_ready[0] <= cyc);
      head     = rsp ? out_q[0] : -1;
      rsp_port = rsp ? tx_port[head] : -1;
      mgr_rsp.gnt    = xfer;
      mgr_rsp.rvalid = rsp;
      mgr_rsp.r      = rsp ? memory_rsp(head) : '0;

      #5;
      compare_bit("manager req", exp_req, mgr_req.req);
      if (exp_req) begin
        compare_a("manager A channel", make_a(cur[chosen]), mgr_req.a);
      end
      act_idx = '0;
      for (int p = 0; p < NumSbrPorts; p++) begin
        if (sbr_rsp[p].gnt) begin
          act_idx = IdxWidth'(p);
        end
      end
      if (xfer) begin
        compare_idx("granted port", IdxWidth'(chosen), act_idx);
      end
      for (int p = 0; p < NumSbrPorts; p++) begin
        compare_bit($sformatf("gnt of port %0d", p), xfer && (p == chosen), sbr_rsp[p].gnt);
        compare_bit($sformatf("rvalid of port %0d", p), rsp && (p == rsp_port),
                    sbr_rsp[p].rvalid);
      end
      if (rsp) begin
        compare_r($sformatf("response on port %0d", rsp_port), file_rsp(head),
                  sbr_rsp[rsp_port].r);
      end

      if (xfer) begin
        k = cur[chosen];
        if (tx_we[k] && !tx_addr[k][31]) begin
          mem[tx_addr[k][7:2]]     = tx_wdata[k];
          mem_vld[tx_addr[k][7:2]] = 1'b1;
        end
        out_q.push_back(k);
        out_ready.push_back(cyc + tx_rdly[k]);
        cur[chosen] = -1;
        wait_cnt    = 0;
        rr_ptr      = (chosen + 1) % int'(NumSbrPorts);
        lock_vld    = 1'b0;
      end else begin
        lock_vld  = arb_req;
        lock_port = chosen;
        if (exp_req) begin
          wait_cnt++;
        end
      end
      if (rsp) begin
        void'(out_q.pop_front());
        void'(out_ready.pop_front());
        done++;
      end
      cyc++;
    end
  endtask

  initial begin : main
    int first;
    int last;
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    sbr_req   = '0;
    mgr_rsp   = '0;
    rr_ptr    = 0;
    lock_vld  = 1'b0;
    lock_port = -1;
    test_name = "reset";
    void'($urandom(28364));
    for (int i = 0; i < 64; i++) begin
      mem[i]     = '0;
      mem_vld[i] = 1'b0;
    end
    load_stim();

    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_idle();
    end
    @(negedge clk_i);
    reset_i = 1'b0;
    check_idle();

    first = 0;
    while (first < num_tx) begin
      last = first;
      while (last + 1 < num_tx && tx_name[last + 1] == tx_name[first]) begin
        last++;
      end
      test_name = tx_name[first];
      run_batch(first, last);
      $display("Test %s finished with %0d transactions.", test_name, last - first + 1);
      first = last + 1;
    end

    @(negedge clk_i);
    sbr_req = '0;
    mgr_rsp = '0;
    test_name = "idle_end";
    check_idle();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/obi_mux.sv ====
/*
 * OBI request multiplexer.
 * Joins several subordinate ports onto one manager port and routes the
 * in-order responses back to the port that issued each request.
 */
`timescale 1ns/100ps
`default_nettype none

module obi_mux #(
  parameter int unsigned NumSbrPorts = 4,
  parameter int unsigned NumMaxTrans = 4
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  obi_mux_pkg::obi_req_t [NumSbrPorts-1:0] sbr_req_i,
  output obi_mux_pkg::obi_rsp_t [NumSbrPorts-1:0] sbr_rsp_o,

  output obi_mux_pkg::obi_req_t                   mgr_req_o,
  input  obi_mux_pkg::obi_rsp_t                   mgr_rsp_i
);

  import obi_mux_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);

  if (NumSbrPorts < 2) begin : gen_ports_err
    $fatal(1, "obi_mux needs at least two subordinate ports");
  end
  if (NumMaxTrans < 1) begin : gen_trans_err
    $fatal(1, "obi_mux needs at least one outstanding transaction");
  end

  logic [NumSbrPorts-1:0]        sbr_req;
  logic [NumSbrPorts-1:0]        sbr_gnt;
  logic [NumSbrPorts-1:0]        sbr_rvalid;
  obi_a_chan_t [NumSbrPorts-1:0] sbr_a;
  obi_r_chan_t [NumSbrPorts-1:0] sbr_r;

  logic                arb_req;
  logic                mgr_req;
  logic                mgr_xfer;
  logic                fifo_full;
  logic                fifo_pop;
  logic [IdxWidth-1:0] sel_idx;
  logic [IdxWidth-1:0] head_idx;
  obi_a_chan_t         mgr_a;

  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_sbr
    assign sbr_req[i]          = sbr_req_i[i].req;
    assign sbr_a[i]            = sbr_req_i[i].a;
    assign sbr_rsp_o[i].gnt    = sbr_gnt[i];
    assign sbr_rsp_o[i].rvalid = sbr_rvalid[i];
    assign sbr_rsp_o[i].r      = sbr_r[i];
  end

  // No new request goes out while NumMaxTrans responses are pending.
  assign mgr_req       = arb_req & ~fifo_full;
  assign mgr_xfer      = mgr_req & mgr_rsp_i.gnt;
  assign mgr_req_o.req = mgr_req;
  assign mgr_req_o.a   = mgr_a;

  obi_rr_arbiter #(
    .NumSbrPorts ( NumSbrPorts )
  ) i_rr_arb (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .req_i   ( sbr_req  ),
    .a_i     ( sbr_a    ),
    .gnt_o   ( sbr_gnt  ),
    .req_o   ( arb_req  ),
    .a_o     ( mgr_a    ),
    .idx_o   ( sel_idx  ),
    .gnt_i   ( mgr_xfer )
  );

  obi_id_fifo #(
    .NumSbrPorts ( NumSbrPorts ),
    .NumMaxTrans ( NumMaxTrans )
  ) i_id_fifo (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( mgr_xfer  ),
    .idx_i   ( sel_idx   ),
    .full_o  ( fifo_full ),
    .pop_i   ( fifo_pop  ),
    .idx_o   ( head_idx  )
  );

  obi_rsp_router #(
    .NumSbrPorts ( NumSbrPorts )
  ) i_rsp_router (
    .mgr_rsp_i    ( mgr_rsp_i.r      ),
    .mgr_rvalid_i ( mgr_rsp_i.rvalid ),
    .head_idx_i   ( head_idx         ),
    .rvalid_o     ( sbr_rvalid       ),
    .r_o          ( sbr_r            ),
    .pop_o        ( fifo_pop         )
  );

endmodule

`default_nettype wire

// ==== src/obi_rsp_router.sv ====
/*
 * Response router of the OBI mux.
 * Steers each manager response to the port at the head of the index
 * FIFO and releases that entry.
 */
`timescale 1ns/100ps
`default_nettype none

module obi_rsp_router #(
  parameter int unsigned NumSbrPorts = 4
) (
  input  obi_mux_pkg::obi_r_chan_t                   mgr_rsp_i,
  input  logic                                       mgr_rvalid_i,
  input  logic [$clog2(NumSbrPorts)-1:0]             head_idx_i,

  output logic [NumSbrPorts-1:0]                     rvalid_o,
  output obi_mux_pkg::obi_r_chan_t [NumSbrPorts-1:0] r_o,
  output logic                                       pop_o
);

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);

  // The R payload goes to every port. Only the owner sees rvalid.
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_port
    assign rvalid_o[i] = mgr_rvalid_i && (head_idx_i == IdxWidth'(i));
    assign r_o[i]      = mgr_rsp_i;
  end

  // Responses arrive in grant order, one entry per rvalid.
  assign pop_o = mgr_rvalid_i;

endmodule

`default_nettype wire

// ==== src/obi_id_fifo.sv ====
/*
 * Index FIFO of the OBI mux.
 * Stores the port index of each granted transfer in grant order and
 * limits the number of transfers still waiting for a response.
 */
`timescale 1ns/100ps
`default_nettype none

module obi_id_fifo #(
  parameter int unsigned NumSbrPorts = 4,
  parameter int unsigned NumMaxTrans = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  logic                           push_i,
  input  logic [$clog2(NumSbrPorts)-1:0] idx_i,
  output logic                           full_o,

  input  logic                           pop_i,
  output logic [$clog2(NumSbrPorts)-1:0] idx_o
);

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);
  localparam int unsigned PtrWidth = (NumMaxTrans > 1) ? $clog2(NumMaxTrans) : 1;
  localparam int unsigned CntWidth = $clog2(NumMaxTrans + 1);

  logic [IdxWidth-1:0] mem_q [NumMaxTrans];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                empty;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(NumMaxTrans - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o = (count_q == CntWidth'(NumMaxTrans));
  assign empty  = (count_q == '0);

  // The head is read from storage, so a push shows up one cycle later.
  assign idx_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= idx_i;
    end
  end

  // The top level removes the manager request while full.
  no_push_when_full : assert property (
    @(posedge clk_i) disable iff (reset_i) push_i |-> !full_o
  ) else $error("Push into a full index FIFO.");

  // A response without an outstanding transfer breaks the in-order routing.
  no_pop_when_empty : assert property (
    @(posedge clk_i) disable iff (reset_i) pop_i |-> !empty
  ) else $error("Pop from an empty index FIFO.");

endmodule

`default_nettype wire

// ==== src/obi_rr_arbiter.sv ====
/*
 * Round-robin arbiter for the OBI mux A channels.
 * Picks one requesting port, holds that choice until it is granted and
 * then moves the priority pointer to one past the granted port.
 */
`timescale 1ns/100ps
`default_nettype none

module obi_rr_arbiter #(
  parameter int unsigned NumSbrPorts = 4
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,

  input  logic [NumSbrPorts-1:0]                       req_i,
  input  obi_mux_pkg::obi_a_chan_t [NumSbrPorts-1:0]   a_i,
  output logic [NumSbrPorts-1:0]                       gnt_o,

  output logic                                         req_o,
  output obi_mux_pkg::obi_a_chan_t                     a_o,
  output logic [$clog2(NumSbrPorts)-1:0]               idx_o,
  input  logic                                         gnt_i
);

  localparam int unsigned IdxWidth = $clog2(NumSbrPorts);

  logic [IdxWidth-1:0] rr_q;
  logic                lock_q;
  logic [IdxWidth-1:0] lock_idx_q;

  logic                found;
  logic [IdxWidth-1:0] found_idx;
  logic [IdxWidth-1:0] sel_idx;

  // Search upwards from the pointer, wrapping at the last port.
  always_comb begin : proc_search
    int unsigned cand;
    found     = 1'b0;
    found_idx = rr_q;
    for (int unsigned i = 0; i < NumSbrPorts; i++) begin
      cand = int'(rr_q) + i;
      if (cand >= NumSbrPorts) begin
        cand = cand - NumSbrPorts;
      end
      if (!found && req_i[cand]) begin
        found     = 1'b1;
        found_idx = cand[IdxWidth-1:0];
      end
    end
  end

  // A choice that waited for a grant stays selected, even if a port
  // with higher priority starts requesting meanwhile.
  assign sel_idx = lock_q ? lock_idx_q : found_idx;
  assign req_o   = lock_q ? req_i[lock_idx_q] : found;
  assign a_o     = a_i[sel_idx];
  assign idx_o   = sel_idx;

  always_comb begin
    gnt_o = '0;
    for (int unsigned i = 0; i < NumSbrPorts; i++) begin
      if (sel_idx == IdxWidth'(i)) begin
        gnt_o[i] = req_o & gnt_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= req_o & ~gnt_i;
      if (req_o && gnt_i) begin
        if (sel_idx == IdxWidth'(NumSbrPorts - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= sel_idx + 1'b1;
        end
      end
    end
  end

  // Index of the choice that waits for its grant.
  always_ff @(posedge clk_i) begin
    lock_idx_q <= sel_idx;
  end

  // A waiting subordinate must keep its A channel, so the manager sees a
  // stable request.
  a_stable_while_waiting : assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_o && !gnt_i |=> $stable(a_o)
  ) else $error("A channel changed while waiting for a grant.");

endmodule

`default_nettype wire

// ==== src/obi_mux_pkg.sv ====
/*
 * OBI mux shared definitions.
 * Channel widths and the packed A, R, request and response structs used on
 * both the subordinate and the manager side.
 */
`default_nettype none

package obi_mux_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  // One request beat as presented by a manager.
  typedef struct packed {
    logic [AddrWidth-1:0]   addr;
    logic                   we;
    logic [DataWidth/8-1:0] be;
    logic [DataWidth-1:0]   wdata;
    logic [IdWidth-1:0]     aid;
  } obi_a_chan_t;

  // One response beat. The rid is passed through unchanged.
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic [IdWidth-1:0]   rid;
    logic                 err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  // There is no rready, so a response cannot be refused.
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

endpackage

`default_nettype wire
